// ==== bench/lms_frontend_chk.sv ====
// Bound assertions on the transmit select and the SPI router outputs
`timescale 1ns/1ps
`default_nettype none

module lms_frontend_chk
(
   input logic               dsp_clk,
   input logic               arst_n_i,
   input lms_pkg::iq_phase_t tx_iqsel_i,    // Select shared by both DAC channels
   input logic               sclk_i,
   input logic               sen_lms1_n_i,
   input logic               sen_lms2_n_i,
   input logic               sclk_dac_i,
   input logic               sclk_lms1_i,
   input logic               mosi_lms1_i,
   input logic               sclk_lms2_i,
   input logic               mosi_lms2_i
);

   // First edge after reset repeats the reset select, then it flips every cycle
   tx_sel_toggles: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      $past(arst_n_i, 2) |-> (tx_iqsel_i != $past(tx_iqsel_i)))
      else $error("Transmit select held its level for two cycles");

   lms1_quiet: assert property (@(posedge dsp_clk)
      sen_lms1_n_i |-> (!sclk_lms1_i && !mosi_lms1_i))
      else $error("Deselected transceiver 1 sees SPI activity");

   lms2_quiet: assert property (@(posedge dsp_clk)
      sen_lms2_n_i |-> (!sclk_lms2_i && !mosi_lms2_i))
      else $error("Deselected transceiver 2 sees SPI activity");

   dac_clk_follows: assert property (@(posedge dsp_clk) sclk_dac_i == sclk_i)
      else $error("DAC SPI clock differs from the master clock");

endmodule

// Attached at the top, where the transmitter select and the SPI lines share one clock
bind lms_frontend lms_frontend_chk frontend_chk
(
   .dsp_clk      (dsp_clk),
   .arst_n_i     (arst_n_i),
   .tx_iqsel_i   (tx_iqsel),
   .sclk_i       (sclk_i),
   .sen_lms1_n_i (sen_lms1_n_i),
   .sen_lms2_n_i (sen_lms2_n_i),
   .sclk_dac_i   (sclk_dac_o),
   .sclk_lms1_i  (sclk_lms1_o),
   .mosi_lms1_i  (mosi_lms1_o),
   .sclk_lms2_i  (sclk_lms2_o),
   .mosi_lms2_i  (mosi_lms2_o)
);

`default_nettype wire

// ==== bench/lms_frontend_tb.sv ====
// Testbench for the LMS front end with clock, reset, random stimulus and reference model
`timescale 1ns/1ps
`default_nettype none

module lms_frontend_tb;

   import lms_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int CHECK_DELAY = 15;    // Just before the next rising edge
   localparam int NUM_CYCLES  = 400;
   localparam int RST_TIMEOUT = 20;

   logic        dsp_clk;
   logic        arst_n;
   lms_sample_t rx1_d, rx2_d;
   iq_phase_t   rx1_iqsel, rx2_iqsel;
   dac_word_t   dac1_i, dac1_q, dac2_i, dac2_q;
   logic        sclk, mosi, sen_dac_n, sen_lms1_n, sen_lms2_n;
   logic        miso_dac, miso_lms1, miso_lms2;

   adc_word_t   rx1_i, rx1_q, rx2_i, rx2_q;
   lms_sample_t tx1_d, tx2_d;
   iq_phase_t   tx1_iqsel, tx2_iqsel;
   logic        sclk_dac, sclk_lms1, mosi_lms1, sclk_lms2, mosi_lms2, miso;
   logic        sen_dac_n_out, sen_lms1_n_out, sen_lms2_n_out;

   // Reference model state
   adc_word_t   m_rx1_i, m_rx1_q, m_rx2_i, m_rx2_q;
   lms_sample_t m_tx1, m_tx2;
   iq_phase_t   m_phase, m_sel;

   integer      seed;
   logic [31:0] rnd;
   integer      word_errs, sample_errs, phase_errs, bit_errs;

   lms_frontend dut_i
   (
      .dsp_clk (dsp_clk), .arst_n_i (arst_n),
      .rx1_d_i (rx1_d), .rx1_iqsel_i (rx1_iqsel), .rx2_d_i (rx2_d), .rx2_iqsel_i (rx2_iqsel),
      .dac1_i_i (dac1_i), .dac1_q_i (dac1_q), .dac2_i_i (dac2_i), .dac2_q_i (dac2_q),
      .sclk_i (sclk), .mosi_i (mosi), .sen_dac_n_i (sen_dac_n),
      .sen_lms1_n_i (sen_lms1_n), .sen_lms2_n_i (sen_lms2_n),
      .miso_dac_i (miso_dac), .miso_lms1_i (miso_lms1), .miso_lms2_i (miso_lms2),
      .rx1_i_o (rx1_i), .rx1_q_o (rx1_q), .rx2_i_o (rx2_i), .rx2_q_o (rx2_q),
      .tx1_d_o (tx1_d), .tx1_iqsel_o (tx1_iqsel), .tx2_d_o (tx2_d), .tx2_iqsel_o (tx2_iqsel),
      .sclk_dac_o (sclk_dac), .sclk_lms1_o (sclk_lms1), .mosi_lms1_o (mosi_lms1),
      .sclk_lms2_o (sclk_lms2), .mosi_lms2_o (mosi_lms2), .miso_o (miso),
      .sen_dac_n_o (sen_dac_n_out), .sen_lms1_n_o (sen_lms1_n_out),
      .sen_lms2_n_o (sen_lms2_n_out)
   );

   initial
   begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   // Released on a falling edge like every other input
   initial
   begin
      arst_n = 1'b0;
      repeat (8) @(posedge dsp_clk);
      @(negedge dsp_clk);
      arst_n = 1'b1;
   end

   task automatic word_check(input string name, input adc_word_t exp, input adc_word_t act);
      if (act !== exp)
      begin
         $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
         word_errs = word_errs + 1;
      end
   endtask

   task automatic sample_check(input string name, input lms_sample_t exp,
                               input lms_sample_t act);
      if (act !== exp)
      begin
         $display("Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
         sample_errs = sample_errs + 1;
      end
   endtask

   task automatic phase_check(input string name, input iq_phase_t exp, input iq_phase_t act);
      if (act !== exp)
      begin
         $display("Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
         phase_errs = phase_errs + 1;
      end
   endtask

   task automatic bit_check(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
         bit_errs = bit_errs + 1;
      end
   endtask

   task automatic drive_inputs();
      rnd = $random(seed);
      rx1_d     = rnd[11:0];
      rx1_iqsel = rnd[12] ? IQ_PHASE_Q : IQ_PHASE_I;
      rx2_d     = rnd[27:16];
      rx2_iqsel = rnd[28] ? IQ_PHASE_Q : IQ_PHASE_I;
      rnd = $random(seed);
      dac1_i = rnd[15:0];
      dac1_q = rnd[31:16];
      rnd = $random(seed);
      dac2_i = rnd[15:0];
      dac2_q = rnd[31:16];
      rnd = $random(seed);
      sclk       = rnd[0];
      mosi       = rnd[1];
      sen_dac_n  = rnd[2];
      sen_lms1_n = rnd[3];
      sen_lms2_n = rnd[4];
      miso_dac   = rnd[5];
      miso_lms1  = rnd[6];
      miso_lms2  = rnd[7];
   endtask

   // One rising edge of the reference model
   task automatic advance_model();
      if (rx1_iqsel == IQ_PHASE_I) m_rx1_i = adc_word_t'(rx1_d);
      else                         m_rx1_q = adc_word_t'(rx1_d);
      if (rx2_iqsel == IQ_PHASE_I) m_rx2_i = adc_word_t'(rx2_d);
      else                         m_rx2_q = adc_word_t'(rx2_d);
      m_sel = m_phase;
      m_tx1 = (m_phase == IQ_PHASE_I) ? lms_sample_t'(dac1_i) : lms_sample_t'(dac1_q);
      m_tx2 = (m_phase == IQ_PHASE_I) ? lms_sample_t'(dac2_i) : lms_sample_t'(dac2_q);
      m_phase = (m_phase == IQ_PHASE_I) ? IQ_PHASE_Q : IQ_PHASE_I;
   endtask

   task automatic reset_values_check();
      word_check("rx1_i_o", '0, rx1_i);
      word_check("rx1_q_o", '0, rx1_q);
      word_check("rx2_i_o", '0, rx2_i);
      word_check("rx2_q_o", '0, rx2_q);
      sample_check("tx1_d_o", '0, tx1_d);
      sample_check("tx2_d_o", '0, tx2_d);
      phase_check("tx1_iqsel_o", IQ_PHASE_I, tx1_iqsel);
      phase_check("tx2_iqsel_o", IQ_PHASE_I, tx2_iqsel);
   endtask

   task automatic compare_outputs();
      word_check("rx1_i_o", m_rx1_i, rx1_i);
      word_check("rx1_q_o", m_rx1_q, rx1_q);
      word_check("rx2_i_o", m_rx2_i, rx2_i);
      word_check("rx2_q_o", m_rx2_q, rx2_q);
      sample_check("tx1_d_o", m_tx1, tx1_d);
      sample_check("tx2_d_o", m_tx2, tx2_d);
      phase_check("tx1_iqsel_o", m_sel, tx1_iqsel);
      phase_check("tx2_iqsel_o", m_sel, tx2_iqsel);
      bit_check("sclk_dac_o", sclk, sclk_dac);
      bit_check("sclk_lms1_o", ~sen_lms1_n & sclk, sclk_lms1);
      bit_check("mosi_lms1_o", ~sen_lms1_n & mosi, mosi_lms1);
      bit_check("sclk_lms2_o", ~sen_lms2_n & sclk, sclk_lms2);
      bit_check("mosi_lms2_o", ~sen_lms2_n & mosi, mosi_lms2);
      bit_check("miso_o", (~sen_dac_n & miso_dac) | (~sen_lms1_n & miso_lms1) |
                          (~sen_lms2_n & miso_lms2), miso);
      bit_check("sen_dac_n_o", sen_dac_n, sen_dac_n_out);
      bit_check("sen_lms1_n_o", sen_lms1_n, sen_lms1_n_out);
      bit_check("sen_lms2_n_o", sen_lms2_n, sen_lms2_n_out);
   endtask

   initial
   begin
      integer guard;
      integer cyc;
      seed = 32'h3bba;
      word_errs = 0;
      sample_errs = 0;
      phase_errs = 0;
      bit_errs = 0;
      {rx1_d, rx2_d, rx1_iqsel, rx2_iqsel} = '0;
      {dac1_i, dac1_q, dac2_i, dac2_q} = '0;
      {sclk, mosi, miso_dac, miso_lms1, miso_lms2} = '0;
      {sen_dac_n, sen_lms1_n, sen_lms2_n} = 3'b111;    // All chips deselected
      {m_rx1_i, m_rx1_q, m_rx2_i, m_rx2_q} = '0;
      {m_tx1, m_tx2} = '0;
      m_phase = IQ_PHASE_I;
      m_sel   = IQ_PHASE_I;

      guard = 0;
      while (arst_n !== 1'b1 && guard < RST_TIMEOUT)
      begin
         @(negedge dsp_clk or posedge arst_n);
         guard = guard + 1;
      end

      if (arst_n !== 1'b1)
      begin
         $display("Timed out waiting for the reset release");
         $display("=== FAIL ===");
      end
      else
      begin
         // Now on the release falling edge, before the first rising edge
         for (cyc = 0; cyc < NUM_CYCLES; cyc = cyc + 1)
         begin
            drive_inputs();
            #(CHECK_DELAY);
            if (cyc == 0) reset_values_check();
            compare_outputs();
            @(posedge dsp_clk);
            advance_model();
            @(negedge dsp_clk);
         end
         $display("Error counts: rx words %0d, tx samples %0d, selects %0d, spi lines %0d",
                  word_errs, sample_errs, phase_errs, bit_errs);
         if (word_errs + sample_errs + phase_errs + bit_errs == 0)
            $display("=== PASS ===");
         else
            $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/lms_defs.svh ====
// Converter bus, received word and transmit word width macros
`ifndef LMS_DEFS_SVH
`define LMS_DEFS_SVH

// Converter bus width of the LMS transceiver where I and Q share the pins
`define LMS_SAMPLE_W 12

// Received word width handed on to the DSP
`define LMS_ADC_W 14

// Transmit word width coming from the DSP
`define LMS_DAC_W 16

`endif

// ==== design/lms_frontend.sv ====
// Top level joining two receive channels, the transmitter and the SPI router
`timescale 1ns/1ps
`default_nettype none

module lms_frontend
(
   input  logic                 dsp_clk,
   input  logic                 arst_n_i,
   input  lms_pkg::lms_sample_t rx1_d_i,
   input  lms_pkg::iq_phase_t   rx1_iqsel_i,
   input  lms_pkg::lms_sample_t rx2_d_i,
   input  lms_pkg::iq_phase_t   rx2_iqsel_i,
   input  lms_pkg::dac_word_t   dac1_i_i,
   input  lms_pkg::dac_word_t   dac1_q_i,
   input  lms_pkg::dac_word_t   dac2_i_i,
   input  lms_pkg::dac_word_t   dac2_q_i,
   input  logic                 sclk_i,
   input  logic                 mosi_i,
   input  logic                 sen_dac_n_i,
   input  logic                 sen_lms1_n_i,
   input  logic                 sen_lms2_n_i,
   input  logic                 miso_dac_i,
   input  logic                 miso_lms1_i,
   input  logic                 miso_lms2_i,
   output lms_pkg::adc_word_t   rx1_i_o,
   output lms_pkg::adc_word_t   rx1_q_o,
   output lms_pkg::adc_word_t   rx2_i_o,
   output lms_pkg::adc_word_t   rx2_q_o,
   output lms_pkg::lms_sample_t tx1_d_o,
   output lms_pkg::iq_phase_t   tx1_iqsel_o,
   output lms_pkg::lms_sample_t tx2_d_o,
   output lms_pkg::iq_phase_t   tx2_iqsel_o,
   output logic                 sclk_dac_o,
   output logic                 sclk_lms1_o,
   output logic                 mosi_lms1_o,
   output logic                 sclk_lms2_o,
   output logic                 mosi_lms2_o,
   output logic                 miso_o,
   output logic                 sen_dac_n_o,
   output logic                 sen_lms1_n_o,
   output logic                 sen_lms2_n_o
);

   import lms_pkg::*;

   iq_phase_t tx_iqsel;    // One phase drives both DAC selects

   // Receive channel 1
   lms_rx_deinterleave rx1_deint
   (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .rx_d_i     (rx1_d_i),
      .rx_iqsel_i (rx1_iqsel_i),
      .adc_i_o    (rx1_i_o),
      .adc_q_o    (rx1_q_o)
   );

   // Receive channel 2
   lms_rx_deinterleave rx2_deint
   (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .rx_d_i     (rx2_d_i),
      .rx_iqsel_i (rx2_iqsel_i),
      .adc_i_o    (rx2_i_o),
      .adc_q_o    (rx2_q_o)
   );

   lms_tx_interleave tx_ileave
   (
      .dsp_clk    (dsp_clk),
      .arst_n_i   (arst_n_i),
      .dac1_i_i   (dac1_i_i),
      .dac1_q_i   (dac1_q_i),
      .dac2_i_i   (dac2_i_i),
      .dac2_q_i   (dac2_q_i),
      .tx1_d_o    (tx1_d_o),
      .tx2_d_o    (tx2_d_o),
      .tx_iqsel_o (tx_iqsel)
   );

   assign tx1_iqsel_o = tx_iqsel;
   assign tx2_iqsel_o = tx_iqsel;

   lms_spi_route spi_route
   (
      .sclk_i       (sclk_i),
      .mosi_i       (mosi_i),
      .sen_dac_n_i  (sen_dac_n_i),
      .sen_lms1_n_i (sen_lms1_n_i),
      .sen_lms2_n_i (sen_lms2_n_i),
      .miso_dac_i   (miso_dac_i),
      .miso_lms1_i  (miso_lms1_i),
      .miso_lms2_i  (miso_lms2_i),
      .sclk_dac_o   (sclk_dac_o),
      .sclk_lms1_o  (sclk_lms1_o),
      .mosi_lms1_o  (mosi_lms1_o),
      .sclk_lms2_o  (sclk_lms2_o),
      .mosi_lms2_o  (mosi_lms2_o),
      .miso_o       (miso_o)
   );

   // Chip selects go straight out to the pins
   assign sen_dac_n_o  = sen_dac_n_i;
   assign sen_lms1_n_o = sen_lms1_n_i;
   assign sen_lms2_n_o = sen_lms2_n_i;

endmodule

`default_nettype wire

// ==== design/lms_pkg.sv ====
// Package with the sample word types and the IQ phase enum
`default_nettype none

`include "lms_defs.svh"

package lms_pkg;

   // One sample as seen on the converter bus
   typedef logic [`LMS_SAMPLE_W-1:0] lms_sample_t;

   typedef logic [`LMS_ADC_W-1:0] adc_word_t;    // Zero-extended receive word
   typedef logic [`LMS_DAC_W-1:0] dac_word_t;    // Only the low bits reach the DAC

   // Transmit phase and meaning of every IQ-select level
   typedef enum logic
   {
      IQ_PHASE_I = 1'b0,
      IQ_PHASE_Q = 1'b1
   } iq_phase_t;

endpackage

`default_nettype wire

// ==== design/lms_rx_deinterleave.sv ====
// Receive I/Q de-interleaver for one transceiver channel
`timescale 1ns/1ps
`default_nettype none

`include "lms_defs.svh"

module lms_rx_deinterleave
(
   input  logic                dsp_clk,
   input  logic                arst_n_i,
   input  lms_pkg::lms_sample_t rx_d_i,      // I and Q alternate on this bus
   input  lms_pkg::iq_phase_t   rx_iqsel_i,  // Tells which word is on the bus
   output lms_pkg::adc_word_t   adc_i_o,
   output lms_pkg::adc_word_t   adc_q_o
);

   import lms_pkg::*;

   adc_word_t rx_ext;

   // Unsigned converter so the upper bits are zero
   assign rx_ext = {{(`LMS_ADC_W - `LMS_SAMPLE_W){1'b0}}, rx_d_i};

   // Select level steers the sample into one word while the other one holds
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         adc_i_o <= '0;
         adc_q_o <= '0;
      end
      else if (rx_iqsel_i == IQ_PHASE_I)
      begin
         adc_i_o <= rx_ext;    // I word
      end
      else
      begin
         adc_q_o <= rx_ext;    // Q word
      end
   end

endmodule

`default_nettype wire

// ==== design/lms_spi_route.sv ====
// SPI clock and data gating per chip select and MISO combining
`timescale 1ns/1ps
`default_nettype none

module lms_spi_route
(
   input  logic sclk_i,
   input  logic mosi_i,
   input  logic sen_dac_n_i,
   input  logic sen_lms1_n_i,
   input  logic sen_lms2_n_i,
   input  logic miso_dac_i,
   input  logic miso_lms1_i,
   input  logic miso_lms2_i,
   output logic sclk_dac_o,
   output logic sclk_lms1_o,
   output logic mosi_lms1_o,
   output logic sclk_lms2_o,
   output logic mosi_lms2_o,
   output logic miso_o
);

   logic dac_sel;
   logic lms1_sel;
   logic lms2_sel;

   // Selects are active low
   assign dac_sel  = ~sen_dac_n_i;
   assign lms1_sel = ~sen_lms1_n_i;
   assign lms2_sel = ~sen_lms2_n_i;

   assign sclk_dac_o  = sclk_i;    // DAC clock runs ungated, as on the board

   // Transceiver lines stay quiet while not selected
   assign sclk_lms1_o = lms1_sel & sclk_i;
   assign mosi_lms1_o = lms1_sel & mosi_i;
   assign sclk_lms2_o = lms2_sel & sclk_i;
   assign mosi_lms2_o = lms2_sel & mosi_i;

   // Only selected chips reach the master
   assign miso_o = (dac_sel & miso_dac_i) | (lms1_sel & miso_lms1_i) |
                   (lms2_sel & miso_lms2_i);

endmodule

`default_nettype wire

// ==== design/lms_tx_interleave.sv ====
// Two-channel transmit I/Q interleaver with its shared phase state
`timescale 1ns/1ps
`default_nettype none

`include "lms_defs.svh"

module lms_tx_interleave
(
   input  logic                 dsp_clk,
   input  logic                 arst_n_i,
   input  lms_pkg::dac_word_t   dac1_i_i,
   input  lms_pkg::dac_word_t   dac1_q_i,
   input  lms_pkg::dac_word_t   dac2_i_i,
   input  lms_pkg::dac_word_t   dac2_q_i,
   output lms_pkg::lms_sample_t tx1_d_o,
   output lms_pkg::lms_sample_t tx2_d_o,
   output lms_pkg::iq_phase_t   tx_iqsel_o    // Shared by both channels
);

   import lms_pkg::*;

   iq_phase_t phase;     // Half-rate phase that toggles every cycle
   iq_phase_t phase_nxt;

   assign phase_nxt = (phase == IQ_PHASE_I) ? IQ_PHASE_Q : IQ_PHASE_I;

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         phase      <= IQ_PHASE_I;
         tx_iqsel_o <= IQ_PHASE_I;
         tx1_d_o    <= '0;
         tx2_d_o    <= '0;
      end
      else
      begin
         phase      <= phase_nxt;
         tx_iqsel_o <= phase;    // Select marks the word sent with it

         // Both channels send the same half of their pair
         if (phase == IQ_PHASE_I)
         begin
            tx1_d_o <= dac1_i_i[`LMS_SAMPLE_W-1:0];
            tx2_d_o <= dac2_i_i[`LMS_SAMPLE_W-1:0];
         end
         else
         begin
            tx1_d_o <= dac1_q_i[`LMS_SAMPLE_W-1:0];
            tx2_d_o <= dac2_q_i[`LMS_SAMPLE_W-1:0];
         end
      end
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/lms_pkg.sv
design/lms_rx_deinterleave.sv
design/lms_tx_interleave.sv
design/lms_spi_route.sv
design/lms_frontend.sv
bench/lms_frontend_chk.sv
bench/lms_frontend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the LMS front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f \
   --top-module lms_frontend_tb -o lms_frontend_sim \
   || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/lms_frontend_sim 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qF "=== PASS ===" && exit 0 || exit 1
